// ==== adc_pkg.sv ====
// ADC side types
// raw converter word and the signed sample made from it
`default_nettype none

`include "corr_consts.svh"

package adc_pkg;

	// offset binary, bits 1:0 unused
	typedef logic [15:0] adc_raw_t;

	typedef logic signed [`SAMPLE_WIDTH-1:0] sample_t;

endpackage

`default_nettype wire

// ==== bin_dft_channel.sv ====
// single ADC channel: offset binary to signed, then one DFT bin at fs/4
// accumulated over each frame of DFT_LEN samples
`timescale 1ns/1ps
`default_nettype none

`include "corr_consts.svh"

module bin_dft_channel (
	input  wire                        data_clk_div,
	input  wire                        reset,
	input  wire adc_pkg::adc_raw_t     raw,
	input  wire                        din_valid,
	output corr_pkg::bin_result_t      bin
);

	logic [`DFT_LEN_LOG2-1:0] frame_idx;   // index of next sample taken
	adc_pkg::sample_t         sample_r;
	logic [`DFT_LEN_LOG2-1:0] sample_idx;
	logic                     sample_vld;

	corr_pkg::bin_word_t x_ext;
	corr_pkg::bin_word_t rot_re;
	corr_pkg::bin_word_t rot_im;
	corr_pkg::bin_word_t acc_re;
	corr_pkg::bin_word_t acc_im;
	logic                first_sample;
	logic                frame_done;

	// stage 1
	always_ff @(posedge data_clk_div) begin
		if (reset) begin
			frame_idx  <= '0;
			sample_vld <= 1'b0;
		end else begin
			sample_vld <= din_valid;
			if (din_valid)
				frame_idx <= frame_idx + 1'b1;  // wraps at DFT_LEN
		end
	end

	always_ff @(posedge data_clk_div) begin
		if (din_valid) begin
			sample_r   <= adc_pkg::sample_t'({~raw[15], raw[14:2]});
			sample_idx <= frame_idx;
		end
	end

	// twiddle cycles 1, -j, -1, +j
	assign x_ext = corr_pkg::bin_word_t'(sample_r);

	always_comb begin
		rot_re = '0;
		rot_im = '0;
		case (sample_idx[1:0])
			2'd0: rot_re = x_ext;
			2'd1: rot_im = -x_ext;
			2'd2: rot_re = -x_ext;
			default: rot_im = x_ext;
		endcase
	end

	assign first_sample = (sample_idx == '0);

	// stage 2, first sample of a frame restarts the sums
	always_ff @(posedge data_clk_div) begin
		if (sample_vld) begin
			acc_re <= (first_sample ? corr_pkg::bin_word_t'(0) : acc_re) + rot_re;
			acc_im <= (first_sample ? corr_pkg::bin_word_t'(0) : acc_im) + rot_im;
		end
	end

	always_ff @(posedge data_clk_div) begin
		if (reset)
			frame_done <= 1'b0;
		else
			frame_done <= sample_vld && (sample_idx == `DFT_LEN_LOG2'(`DFT_LEN - 1));
	end

	// result held until next frame completes
	always_ff @(posedge data_clk_div) begin
		if (reset) begin
			bin <= '0;
		end else if (frame_done) begin
			bin <= '{valid: 1'b1, re: acc_re, im: acc_im};
		end else begin
			bin.valid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== corr_consts.svh ====
// project-wide constants for the two-channel single-bin correlator
// frame length and the full-precision widths derived from it

`ifndef CORR_CONSTS_SVH
`define CORR_CONSTS_SVH

// samples per DFT frame, power of two
`define DFT_LEN 16
`define DFT_LEN_LOG2 4

// signed ADC sample after offset-binary conversion
`define SAMPLE_WIDTH 14

// bin sum of DFT_LEN samples, no truncation
`define BIN_WIDTH 18

// summed squares of two bins over up to 255 frames
`define CORR_WIDTH 48

// integration length in frames
`define ACC_LEN_WIDTH 8

`endif

// ==== corr_pkg.sv ====
// bin and correlation result types
// bins travel as one struct per channel, the four power terms as another
`default_nettype none

`include "corr_consts.svh"

package corr_pkg;

	typedef logic signed [`BIN_WIDTH-1:0] bin_word_t;

	typedef struct packed {
		logic      valid;  // one cycle per frame
		bin_word_t re;
		bin_word_t im;
	} bin_result_t;

	typedef logic signed [`CORR_WIDTH-1:0] corr_word_t;

	typedef struct packed {
		corr_word_t aa;
		corr_word_t bb;
		corr_word_t ab_re;
		corr_word_t ab_im;
	} corr_result_t;

	typedef logic [`ACC_LEN_WIDTH-1:0] acc_len_t;

endpackage

`default_nettype wire

// ==== cross_correlator.sv ====
// auto and cross power of two DFT bins, integrated over acc_len frames
// publishes the four sums with a one-cycle dout_valid
`timescale 1ns/1ps
`default_nettype none

module cross_correlator (
	input  wire                         data_clk_div,
	input  wire                         reset,
	input  wire corr_pkg::bin_result_t  bin0,
	input  wire corr_pkg::bin_result_t  bin1,
	input  wire corr_pkg::acc_len_t     acc_len,
	output corr_pkg::corr_result_t      corr,
	output logic                        dout_valid
);

	corr_pkg::corr_word_t re0;
	corr_pkg::corr_word_t im0;
	corr_pkg::corr_word_t re1;
	corr_pkg::corr_word_t im1;

	corr_pkg::corr_result_t prod;
	logic                   prod_vld;
	corr_pkg::corr_result_t acc;
	corr_pkg::corr_result_t sum;

	corr_pkg::acc_len_t frame_cnt;  // frames already in acc
	corr_pkg::acc_len_t len_r;
	corr_pkg::acc_len_t len_now;
	logic               first_frame;
	logic               last_frame;

	// sign extend to full precision before multiplying
	assign re0 = corr_pkg::corr_word_t'(bin0.re);
	assign im0 = corr_pkg::corr_word_t'(bin0.im);
	assign re1 = corr_pkg::corr_word_t'(bin1.re);
	assign im1 = corr_pkg::corr_word_t'(bin1.im);

	// product stage
	always_ff @(posedge data_clk_div) begin
		if (reset)
			prod_vld <= 1'b0;
		else
			prod_vld <= bin0.valid && bin1.valid;
	end

	always_ff @(posedge data_clk_div) begin
		if (bin0.valid && bin1.valid) begin
			prod.aa    <= re0 * re0 + im0 * im0;
			prod.bb    <= re1 * re1 + im1 * im1;
			prod.ab_re <= re0 * re1 + im0 * im1;  // x0 * conj(x1)
			prod.ab_im <= im0 * re1 - re0 * im1;
		end
	end

	// integration stage
	assign first_frame = (frame_cnt == '0);

	// acc_len taken at the first frame, zero means one
	assign len_now = !first_frame ? len_r :
		(acc_len == '0) ? corr_pkg::acc_len_t'(1) : acc_len;

	assign last_frame = (frame_cnt == len_now - 1'b1);

	always_comb begin
		sum = prod;
		if (!first_frame) begin
			sum.aa    = acc.aa + prod.aa;
			sum.bb    = acc.bb + prod.bb;
			sum.ab_re = acc.ab_re + prod.ab_re;
			sum.ab_im = acc.ab_im + prod.ab_im;
		end
	end

	always_ff @(posedge data_clk_div) begin
		if (prod_vld) begin
			acc <= sum;
			if (first_frame)
				len_r <= len_now;
		end
	end

	always_ff @(posedge data_clk_div) begin
		if (reset) begin
			frame_cnt  <= '0;
			dout_valid <= 1'b0;
			corr       <= '0;
		end else begin
			dout_valid <= 1'b0;
			if (prod_vld) begin
				if (last_frame) begin
					frame_cnt  <= '0;  // next frame opens a new integration
					corr       <= sum;
					dout_valid <= 1'b1;
				end else begin
					frame_cnt <= frame_cnt + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+.
adc_pkg.sv
corr_pkg.sv
bin_dft_channel.sv
cross_correlator.sv
xcorr_top.sv
xcorr_sva.sv
xcorr_tb.sv

// ==== xcorr_sva.sv ====
// assertions on the correlator top level
// bin valid alignment and dout_valid pulse shape
`timescale 1ns/1ps
`default_nettype none

module xcorr_sva (
	input wire data_clk_div,
	input wire reset,
	input wire bin0_valid,
	input wire bin1_valid,
	input wire dout_valid
);

	int fail_count = 0;

	a_bins_aligned: assert property (@(posedge data_clk_div) disable iff (reset)
		bin0_valid == bin1_valid)
	else begin
		fail_count++;
		$error("bin valid of the two channels differ");
	end

	a_dout_single: assert property (@(posedge data_clk_div) disable iff (reset)
		dout_valid |=> !dout_valid)
	else begin
		fail_count++;
		$error("dout_valid high on two consecutive cycles");
	end

	// covers reset itself and the first cycle out of reset
	a_dout_reset: assert property (@(posedge data_clk_div)
		reset |=> !dout_valid ##1 !dout_valid)
	else begin
		fail_count++;
		$error("dout_valid high in or just after reset");
	end

endmodule

bind xcorr_top xcorr_sva xcorr_sva_inst (
	.data_clk_div (data_clk_div),
	.reset        (reset),
	.bin0_valid   (bin0.valid),
	.bin1_valid   (bin1.valid),
	.dout_valid   (dout_valid)
);

`default_nettype wire

// ==== xcorr_tb.sv ====
// testbench for the two-channel cross-correlator
// seeded random samples, reference model of bins and integration
`timescale 1ns/1ps
`default_nettype none

`include "corr_consts.svh"

module xcorr_tb;

	localparam int CLK_PERIOD = 40;
	localparam int RAND_INTS = 6;
	// samples scheduled by all tests, random acc_len counted at its maximum
	localparam int SAMPLE_BUDGET = 192 + 128 + RAND_INTS * 8 * 16 + 16 + 255 * 16 + 24 + 48;
	localparam int WATCHDOG_CYCLES = SAMPLE_BUDGET * 4 + 200;

	logic                   data_clk_div = 1'b0;
	logic                   reset;
	adc_pkg::adc_raw_t      adc0_raw;
	adc_pkg::adc_raw_t      adc1_raw;
	logic                   din_valid;
	corr_pkg::acc_len_t     acc_len;
	corr_pkg::corr_result_t corr;
	logic                   dout_valid;

	integer seed = 97;
	int     errors = 0;
	int     mismatches = 0;
	int     sent_idx = 0;

	// model state
	longint                 cyc = 0;
	int                     m_idx;
	int                     m_frames;
	int                     m_len;
	longint                 m_re0, m_im0, m_re1, m_im1;
	longint                 s_aa, s_bb, s_ab_re, s_ab_im;
	corr_pkg::corr_result_t exp_q[$];
	longint                 exp_cyc[$];

	xcorr_top xcorr_top_inst (
		.data_clk_div (data_clk_div),
		.reset        (reset),
		.adc0_raw     (adc0_raw),
		.adc1_raw     (adc1_raw),
		.din_valid    (din_valid),
		.acc_len      (acc_len),
		.corr         (corr),
		.dout_valid   (dout_valid)
	);

	always #(CLK_PERIOD / 2) data_clk_div = ~data_clk_div;

	// offset binary: code 0 is most negative
	function automatic int to_sample(input logic [15:0] raw);
		return int'(raw[15:2]) - 8192;
	endfunction

	task automatic rotate_add(input int x, input int k, inout longint re, inout longint im);
		case (k % 4)
			0: re = re + x;
			1: im = im - x;
			2: re = re - x;
			default: im = im + x;
		endcase
	endtask

	task automatic close_frame();
		corr_pkg::corr_result_t e;
		if (m_frames == 0) begin
			m_len = (acc_len == 0) ? 1 : int'(acc_len);
			s_aa = 0;
			s_bb = 0;
			s_ab_re = 0;
			s_ab_im = 0;
		end
		s_aa += m_re0 * m_re0 + m_im0 * m_im0;
		s_bb += m_re1 * m_re1 + m_im1 * m_im1;
		s_ab_re += m_re0 * m_re1 + m_im0 * m_im1;
		s_ab_im += m_im0 * m_re1 - m_re0 * m_im1;
		m_frames++;
		if (m_frames == m_len) begin
			e.aa = s_aa;
			e.bb = s_bb;
			e.ab_re = s_ab_re;
			e.ab_im = s_ab_im;
			exp_q.push_back(e);
			exp_cyc.push_back(cyc + 4);  // bin, product, publish
			m_frames = 0;
		end
	endtask

	always @(posedge data_clk_div) begin
		cyc = cyc + 1;
		if (reset) begin
			m_idx = 0;
			m_frames = 0;
			exp_q.delete();
			exp_cyc.delete();
		end else if (din_valid) begin
			if (m_idx == 0) begin
				m_re0 = 0;
				m_im0 = 0;
				m_re1 = 0;
				m_im1 = 0;
			end
			rotate_add(to_sample(adc0_raw), m_idx, m_re0, m_im0);
			rotate_add(to_sample(adc1_raw), m_idx, m_re1, m_im1);
			if (m_idx == `DFT_LEN - 1)
				close_frame();
			m_idx = (m_idx + 1) % `DFT_LEN;
		end
	end

	task automatic compare_field(input string name, input corr_pkg::corr_word_t expv,
			input corr_pkg::corr_word_t actv);
		assert (actv == expv) else begin
			mismatches++;
			$display("CHECK FAILED time=%0t %s expected=%0d actual=%0d", $time, name, expv, actv);
		end
	endtask

	always @(negedge data_clk_div) begin : check_output
		corr_pkg::corr_result_t e;
		longint                 ec;
		if (!reset && dout_valid) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("dout_valid at %0t with no result due from the model", $time);
			end else begin
				e = exp_q.pop_front();
				ec = exp_cyc.pop_front();
				assert (cyc == ec) else begin
					mismatches++;
					$display("CHECK FAILED time=%0t dout_valid_cycle expected=%0d actual=%0d",
						$time, ec, cyc);
				end
				compare_field("corr.aa", e.aa, corr.aa);
				compare_field("corr.bb", e.bb, corr.bb);
				compare_field("corr.ab_re", e.ab_re, corr.ab_re);
				compare_field("corr.ab_im", e.ab_im, corr.ab_im);
			end
		end
	end

	// extreme mode drives channel 0 for the largest bin and channel 1 at the rails
	task automatic send_samples(input int count, input int gap_pct, input bit extreme);
		int taken;
		int r;
		int k;
		taken = 0;
		while (taken < count) begin
			@(negedge data_clk_div);
			r = $random(seed);
			if (gap_pct > 0 && ((r & 32'h7fff_ffff) % 100) < gap_pct) begin
				din_valid = 1'b0;
			end else begin
				k = sent_idx % 4;
				if (extreme) begin
					adc0_raw = (k == 0 || k == 3) ? 16'hFFFC : 16'h0000;
					adc1_raw = ($random(seed) & 1) ? 16'hFFFC : 16'h0000;
				end else begin
					adc0_raw = $random(seed);
					adc1_raw = $random(seed);
				end
				din_valid = 1'b1;
				sent_idx++;
				taken++;
			end
		end
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) begin
			@(negedge data_clk_div);
			din_valid = 1'b0;
		end
	endtask

	task automatic drain();
		idle(1);
		while (exp_q.size() != 0)
			@(posedge data_clk_div);
		idle(2);
	endtask

	task automatic apply_reset(input int cycles);
		@(negedge data_clk_div);
		din_valid = 1'b0;
		reset = 1'b1;
		idle(cycles);
		reset = 1'b0;
		sent_idx = 0;
	endtask

	initial begin : watchdog
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: %0d expected results never arrived", exp_q.size());
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin : stimulus
		int len;
		int total_errors;
		reset = 1'b1;
		din_valid = 1'b0;
		adc0_raw = '0;
		adc1_raw = '0;
		acc_len = 8'd1;
		idle(10);  // reset high from time zero
		reset = 1'b0;

		// one result per frame, continuous input
		send_samples(192, 0, 1'b0);
		drain();

		// gapped input only pauses the frame
		acc_len = 8'd2;
		send_samples(128, 30, 1'b0);
		drain();

		// random integration lengths, acc_len moved after the first frame is latched
		for (int i = 0; i < RAND_INTS; i++) begin
			len = 1 + (($random(seed) & 32'h7fff_ffff) % 8);
			acc_len = corr_pkg::acc_len_t'(len);
			send_samples(16, 10, 1'b0);
			idle(5);
			acc_len = $random(seed);
			send_samples((len - 1) * 16, 10, 1'b0);
			drain();
		end
		acc_len = 8'd0;  // counts as one frame
		send_samples(16, 0, 1'b0);
		drain();

		// full scale over the longest integration
		acc_len = 8'd255;
		send_samples(255 * 16, 0, 1'b1);
		drain();

		// reset in mid-frame and mid-integration
		acc_len = 8'd3;
		send_samples(24, 20, 1'b0);
		apply_reset(3);
		acc_len = 8'd1;
		send_samples(48, 20, 1'b0);
		drain();

		total_errors = errors + xcorr_top_inst.xcorr_sva_inst.fail_count;
		$display("errors=%0d mismatches=%0d", total_errors, mismatches);
		if (total_errors == 0 && mismatches == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== xcorr_top.sv ====
// two-channel single-bin cross-correlator
// per-channel DFT bins feed one correlator
`timescale 1ns/1ps
`default_nettype none

module xcorr_top (
	input  wire                         data_clk_div,
	input  wire                         reset,
	input  wire adc_pkg::adc_raw_t      adc0_raw,
	input  wire adc_pkg::adc_raw_t      adc1_raw,
	input  wire                         din_valid,
	input  wire corr_pkg::acc_len_t     acc_len,
	output corr_pkg::corr_result_t      corr,
	output logic                        dout_valid
);

	corr_pkg::bin_result_t bin0;
	corr_pkg::bin_result_t bin1;

	bin_dft_channel chan0_inst (
		.data_clk_div (data_clk_div),
		.reset        (reset),
		.raw          (adc0_raw),
		.din_valid    (din_valid),
		.bin          (bin0)
	);

	bin_dft_channel chan1_inst (
		.data_clk_div (data_clk_div),
		.reset        (reset),
		.raw          (adc1_raw),
		.din_valid    (din_valid),  // shared, keeps both frames aligned
		.bin          (bin1)
	);

	cross_correlator correlator_inst (
		.data_clk_div (data_clk_div),
		.reset        (reset),
		.bin0         (bin0),
		.bin1         (bin1),
		.acc_len      (acc_len),
		.corr         (corr),
		.dout_valid   (dout_valid)
	);

endmodule

`default_nettype wire
